// File: dma_cluster.f
hw/dma_pkg.sv
hw/dma_reg_file.sv
hw/dma_launch_ctrl.sv
hw/dma_backend.sv
hw/dma_cluster_top.sv
tb/tb_dma_mem_model.sv
tb/tb_dma_cluster.sv

// File: Makefile
# Verilator build and run for the cluster DMA frontend

VERILATOR ?= verilator
TOP       ?= tb_dma_cluster
RTL_TOP   ?= dma_cluster_top
FILELIST  ?= dma_cluster.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert

RTL_FILES := $(shell grep '^hw/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^Simulation passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_dma_cluster.sv
/*
 * testbench for the cluster DMA frontend, core access tasks,
 * launch reference model, copy checks and event counting
 */
`timescale 1ns/10ps
module tb_dma_cluster;

    localparam int NumCtrl = 2;
    localparam int NumStreams = 2;
    localparam int MemAddrWidth = 16;
    localparam int PeriphIdWidth = 4;
    localparam int Timeout = 2000;

    logic clk_i;
    logic reset_i;
    logic [NumCtrl-1:0] ctrl_req, ctrl_we;
    logic [NumCtrl-1:0][9:0] ctrl_addr;
    logic [NumCtrl-1:0][31:0] ctrl_wdata;
    logic [NumCtrl-1:0][PeriphIdWidth-1:0] ctrl_id;
    logic [NumCtrl-1:0] ctrl_gnt_o, ctrl_r_valid_o, ctrl_r_opc_o;
    logic [NumCtrl-1:0][31:0] ctrl_r_data_o;
    logic [NumCtrl-1:0][PeriphIdWidth-1:0] ctrl_r_id_o;
    logic [NumStreams-1:0] mem_req_o, mem_we_o, mem_gnt_i;
    logic [NumStreams-1:0][MemAddrWidth-1:0] mem_addr_o;
    logic [NumStreams-1:0][31:0] mem_wdata_o, mem_rdata_i;
    logic busy_o;
    logic [NumCtrl-1:0] term_event_o, term_irq_o;

    int errors = 0;
    int checks = 0;
    int tag_cnt = 0;
    int n_acc = 0;
    int rr_ref = 0;
    int exp_events = 0;
    int alloc = 0;
    int next_id_ref [NumStreams];
    int event_cnt [NumCtrl];
    // launched copies still to be checked
    int xfer_stream [$];
    int xfer_src [$];
    int xfer_dst [$];
    int xfer_words [$];

    always #5 clk_i = ~clk_i;

    dma_cluster_top #(
        .NumCtrl(NumCtrl),
        .NumStreams(NumStreams),
        .MemAddrWidth(MemAddrWidth),
        .PeriphIdWidth(PeriphIdWidth)
    ) DUT (
        .clk_i(clk_i),
        .reset_i(reset_i),
        .ctrl_req_i(ctrl_req),
        .ctrl_we_i(ctrl_we),
        .ctrl_addr_i(ctrl_addr),
        .ctrl_wdata_i(ctrl_wdata),
        .ctrl_id_i(ctrl_id),
        .ctrl_gnt_o(ctrl_gnt_o),
        .ctrl_r_valid_o(ctrl_r_valid_o),
        .ctrl_r_data_o(ctrl_r_data_o),
        .ctrl_r_opc_o(ctrl_r_opc_o),
        .ctrl_r_id_o(ctrl_r_id_o),
        .mem_req_o(mem_req_o),
        .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o),
        .mem_gnt_i(mem_gnt_i),
        .mem_rdata_i(mem_rdata_i),
        .busy_o(busy_o),
        .term_event_o(term_event_o),
        .term_irq_o(term_irq_o)
    );

    for (genvar s = 0; s < NumStreams; s++) begin : gen_mem
        tb_dma_mem_model #(
            .MemAddrWidth(MemAddrWidth)
        ) i_mem (
            .clk_i(clk_i),
            .reset_i(reset_i),
            .req_i(mem_req_o[s]),
            .we_i(mem_we_o[s]),
            .addr_i(mem_addr_o[s]),
            .wdata_i(mem_wdata_o[s]),
            .gnt_o(mem_gnt_i[s]),
            .rdata_o(mem_rdata_i[s])
        );
    end

    for (genvar c = 0; c < NumCtrl; c++) begin : gen_core_checks
        // response exactly one cycle after the granting edge
        a_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
                ctrl_gnt_o[c] |=> ctrl_r_valid_o[c])
            else begin
                errors++;
                $display("mismatch at %0t: core %0d r_valid missing after gnt", $time, c);
            end
        a_irq: assert property (@(posedge clk_i) disable iff (reset_i)
                term_irq_o[c] == term_event_o[c])
            else begin
                errors++;
                $display("mismatch at %0t: core %0d irq differs from event", $time, c);
            end
    end

    always @(posedge clk_i) begin
        if (!reset_i) begin
            for (int c = 0; c < NumCtrl; c++) begin
                if (term_event_o[c]) begin
                    event_cnt[c]++;
                end
            end
        end
    end

    function automatic logic [31:0] peek(input int s, input int addr);
        logic [13:0] w;
        w = 14'(addr >> 2);
        if (s == 0) begin
            return gen_mem[0].i_mem.mem[w];
        end
        return gen_mem[1].i_mem.mem[w];
    endfunction

    // word of the reference image, as preloaded before any copy
    function automatic logic [31:0] preload(input int s, input int addr);
        logic [13:0] w;
        w = 14'(addr >> 2);
        if (s == 0) begin
            return gen_mem[0].i_mem.init_mem[w];
        end
        return gen_mem[1].i_mem.init_mem[w];
    endfunction

    task automatic expect_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("mismatch at %0t: %s", $time, msg);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("Simulation failed");
        $finish;
    endtask

    // one peripheral access, returns read data, opc and the grant time
    task automatic core_access(input int c, input bit we, input logic [9:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic opc, output time gnt_time);
        int waited;
        logic [PeriphIdWidth-1:0] tag;
        tag = PeriphIdWidth'(tag_cnt);
        tag_cnt++;
        waited = 0;
        @(posedge clk_i);
        ctrl_req[c] <= 1'b1;
        ctrl_we[c] <= we;
        ctrl_addr[c] <= addr;
        ctrl_wdata[c] <= wdata;
        ctrl_id[c] <= tag;
        @(negedge clk_i);
        while (!ctrl_gnt_o[c]) begin
            if (waited == Timeout) begin
                abort_run($sformatf("no grant for core %0d", c));
            end
            waited++;
            @(negedge clk_i);
        end
        gnt_time = $time;
        @(posedge clk_i);
        ctrl_req[c] <= 1'b0;
        @(negedge clk_i);
        expect_true(ctrl_r_valid_o[c] && ctrl_r_id_o[c] == tag,
                    $sformatf("core %0d response id %0d, expected %0d",
                              c, ctrl_r_id_o[c], tag));
        rdata = ctrl_r_data_o[c];
        opc = ctrl_r_opc_o[c];
    endtask

    task automatic write_reg(input int c, input logic [9:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic opc;
        time t;
        core_access(c, 1'b1, addr, data, rd, opc, t);
        expect_true(!opc, $sformatf("write to 0x%0h flagged unmapped", addr));
    endtask

    task automatic read_reg(input int c, input logic [9:0] addr, output logic [31:0] data);
        logic opc;
        time t;
        core_access(c, 1'b0, addr, 32'd0, data, opc, t);
    endtask

    task automatic set_descriptor(input int c, input int words, output int src, output int dst);
        src = 'h100 * alloc;
        dst = 'h8000 + 'h100 * alloc;
        alloc++;
        write_reg(c, dma_pkg::SRC_OFFSET, 32'(src));
        write_reg(c, dma_pkg::DST_OFFSET, 32'(dst));
        write_reg(c, dma_pkg::NUM_BYTES_OFFSET, 32'(words * 4));
    endtask

    // reply of the launch that is accepted ahead places from now
    function automatic logic [31:0] expected_reply(input int ahead);
        int s;
        s = (n_acc + ahead) % NumStreams;
        return {4'(s), 28'(next_id_ref[s])};
    endfunction

    function automatic void accept_ref(input int c, input int src, input int dst, input int words);
        int s;
        s = n_acc % NumStreams;
        xfer_stream.push_back(s);
        xfer_src.push_back(src);
        xfer_dst.push_back(dst);
        xfer_words.push_back(words);
        next_id_ref[s]++;
        n_acc++;
        rr_ref = (c + 1) % NumCtrl;
        exp_events++;
    endfunction

    task automatic launch(input int c, input int words);
        int src, dst;
        logic [31:0] exp, rd;
        set_descriptor(c, words, src, dst);
        exp = expected_reply(0);
        read_reg(c, dma_pkg::NEXT_ID_OFFSET, rd);
        expect_true(rd == exp, $sformatf("launch reply 0x%0h, expected 0x%0h", rd, exp));
        accept_ref(c, src, dst, words);
    endtask

    // poll every done-id register, then compare copies against the source image
    task automatic wait_all_done();
        logic [31:0] rd;
        int polls;
        int s;
        for (int k = 0; k < NumStreams; k++) begin
            polls = 0;
            read_reg(0, 10'(dma_pkg::DONE_OFFSET + 4 * k), rd);
            while (rd != 32'(next_id_ref[k] - 1)) begin
                if (polls == Timeout) begin
                    abort_run($sformatf("stream %0d never retired its last id", k));
                end
                polls++;
                read_reg(0, 10'(dma_pkg::DONE_OFFSET + 4 * k), rd);
            end
        end
        while (xfer_stream.size() > 0) begin
            s = xfer_stream.pop_front();
            for (int i = 0; i < xfer_words[0]; i++) begin
                expect_true(peek(s, xfer_dst[0] + 4 * i) == preload(s, xfer_src[0] + 4 * i),
                            $sformatf("stream %0d word 0x%0h not copied", s,
                                      xfer_dst[0] + 4 * i));
            end
            void'(xfer_src.pop_front());
            void'(xfer_dst.pop_front());
            void'(xfer_words.pop_front());
        end
        read_reg(1, dma_pkg::STATUS_OFFSET, rd);
        expect_true(rd == 32'd0, "status busy after all streams retired");
    endtask

    initial begin
        logic [31:0] rd, rd_a, rd_b, exp_a, exp_b;
        logic opc;
        time t_a, t_b;
        int first, src_a, dst_a, src_b, dst_b;
        clk_i = 1'b0;
        reset_i = 1'b1;
        ctrl_req = '0;
        ctrl_we = '0;
        ctrl_addr = '0;
        ctrl_wdata = '0;
        ctrl_id = '0;
        for (int s = 0; s < NumStreams; s++) begin
            next_id_ref[s] = 1;
        end
        for (int c = 0; c < NumCtrl; c++) begin
            event_cnt[c] = 0;
        end
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        expect_true(ctrl_gnt_o == '0 && ctrl_r_valid_o == '0 && mem_req_o == '0
                    && term_event_o == '0 && term_irq_o == '0 && !busy_o,
                    "outputs not quiet after reset");

        // register access
        write_reg(0, dma_pkg::SRC_OFFSET, 32'h1234);
        write_reg(0, dma_pkg::DST_OFFSET, 32'h5678);
        write_reg(0, dma_pkg::NUM_BYTES_OFFSET, 32'h40);
        read_reg(0, dma_pkg::SRC_OFFSET, rd);
        expect_true(rd == 32'h1234, $sformatf("src reads 0x%0h", rd));
        read_reg(0, dma_pkg::DST_OFFSET, rd);
        expect_true(rd == 32'h5678, $sformatf("dst reads 0x%0h", rd));
        read_reg(0, dma_pkg::NUM_BYTES_OFFSET, rd);
        expect_true(rd == 32'h40, $sformatf("num_bytes reads 0x%0h", rd));
        core_access(1, 1'b0, 10'h002, 32'd0, rd, opc, t_a);
        expect_true(opc == 1'b1, "unmapped offset without r_opc");
        read_reg(1, 10'(dma_pkg::DONE_OFFSET + 4 * NumStreams), rd);
        expect_true(rd == dma_pkg::BAD_ACCESS, $sformatf("done-id past streams 0x%0h", rd));

        // zero byte count launches nothing
        write_reg(0, dma_pkg::NUM_BYTES_OFFSET, 32'd0);
        read_reg(0, dma_pkg::NEXT_ID_OFFSET, rd);
        expect_true(rd == 32'd0, $sformatf("empty launch returned 0x%0h", rd));

        // rotation 0,1,0,1 with back-pressure on the fourth
        launch(0, 2);
        launch(0, 12);
        launch(0, 2);
        launch(0, 12);
        read_reg(1, dma_pkg::STATUS_OFFSET, rd);
        expect_true(rd == 32'd1, "status idle while a copy runs");
        wait_all_done();

        // both cores launch in the same cycle
        set_descriptor(0, 2, src_a, dst_a);
        set_descriptor(1, 12, src_b, dst_b);
        first = rr_ref;
        exp_a = expected_reply(first == 0 ? 0 : 1);
        exp_b = expected_reply(first == 1 ? 0 : 1);
        fork
            core_access(0, 1'b0, dma_pkg::NEXT_ID_OFFSET, 32'd0, rd_a, opc, t_a);
            core_access(1, 1'b0, dma_pkg::NEXT_ID_OFFSET, 32'd0, rd_b, opc, t_b);
        join
        expect_true(rd_a == exp_a, $sformatf("core 0 reply 0x%0h, expected 0x%0h", rd_a, exp_a));
        expect_true(rd_b == exp_b, $sformatf("core 1 reply 0x%0h, expected 0x%0h", rd_b, exp_b));
        expect_true(first == 0 ? t_a < t_b : t_b < t_a, "round-robin order not kept");
        if (first == 0) begin
            accept_ref(0, src_a, dst_a, 2);
            accept_ref(1, src_b, dst_b, 12);
        end else begin
            accept_ref(1, src_b, dst_b, 12);
            accept_ref(0, src_a, dst_a, 2);
        end
        wait_all_done();

        for (int c = 0; c < NumCtrl; c++) begin
            expect_true(event_cnt[c] == exp_events,
                        $sformatf("core %0d saw %0d events, expected %0d",
                                  c, event_cnt[c], exp_events));
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb/tb_dma_mem_model.sv
/*
 * word memory for one stream, preloaded from a Galois LFSR with a copy of
 * the preload as reference image, random grant stalls, one-cycle read latency
 */
`timescale 1ns/10ps
module tb_dma_mem_model #(
    parameter int unsigned MemAddrWidth = 16
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic req_i,
    input  logic we_i,
    input  logic [MemAddrWidth-1:0] addr_i,
    input  logic [31:0] wdata_i,
    output logic gnt_o,
    output logic [31:0] rdata_o
);

    localparam int unsigned Words = 2 ** (MemAddrWidth - 2);

    logic [31:0] mem [Words];
    // untouched preload, the image copies are compared against
    logic [31:0] init_mem [Words];
    logic [31:0] lfsr_q;
    logic [31:0] lfsr_one;
    logic stall;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one LFSR bit per data bit, xor'ed with the word address
    initial begin
        logic [31:0] state;
        logic [31:0] w;
        state = 32'd99;
        for (int i = 0; i < Words; i++) begin
            for (int b = 0; b < 32; b++) begin
                w[b] = state[0];
                state = lfsr_next(state);
            end
            mem[i] = w ^ 32'(i);
            init_mem[i] = mem[i];
        end
    end

    // two bits per cycle, stall when both are set
    assign lfsr_one = lfsr_next(lfsr_q);
    assign stall = lfsr_q[0] && lfsr_one[0];
    assign gnt_o = req_i && !stall;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lfsr_q <= 32'd99;
        end else begin
            lfsr_q <= lfsr_next(lfsr_one);
        end
        if (req_i && gnt_o) begin
            if (we_i) begin
                mem[addr_i[MemAddrWidth-1:2]] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i[MemAddrWidth-1:2]];
            end
        end
    end

endmodule

// File: hw/dma_cluster_top.sv
/*
 * cluster DMA frontend top, register files per core,
 * launch control and one copy backend per stream
 */
`timescale 1ns/10ps
module dma_cluster_top #(
    parameter int unsigned NumCtrl = 2,
    parameter int unsigned NumStreams = 2,
    parameter int unsigned MemAddrWidth = 16,
    parameter int unsigned PeriphIdWidth = 4
) (
    input  logic clk_i,
    input  logic reset_i,
    // peripheral target ports, one per core
    input  logic [NumCtrl-1:0] ctrl_req_i,
    input  logic [NumCtrl-1:0] ctrl_we_i,
    input  logic [NumCtrl-1:0][dma_pkg::REG_ADDR_W-1:0] ctrl_addr_i,
    input  logic [NumCtrl-1:0][31:0] ctrl_wdata_i,
    input  logic [NumCtrl-1:0][PeriphIdWidth-1:0] ctrl_id_i,
    output logic [NumCtrl-1:0] ctrl_gnt_o,
    output logic [NumCtrl-1:0] ctrl_r_valid_o,
    output logic [NumCtrl-1:0][31:0] ctrl_r_data_o,
    output logic [NumCtrl-1:0] ctrl_r_opc_o,
    output logic [NumCtrl-1:0][PeriphIdWidth-1:0] ctrl_r_id_o,
    // memory ports, one per stream
    output logic [NumStreams-1:0] mem_req_o,
    output logic [NumStreams-1:0] mem_we_o,
    output logic [NumStreams-1:0][MemAddrWidth-1:0] mem_addr_o,
    output logic [NumStreams-1:0][31:0] mem_wdata_o,
    input  logic [NumStreams-1:0] mem_gnt_i,
    input  logic [NumStreams-1:0][31:0] mem_rdata_i,
    // status and events
    output logic busy_o,
    output logic [NumCtrl-1:0] term_event_o,
    output logic [NumCtrl-1:0] term_irq_o
);

    logic [NumCtrl-1:0] launch_req, launch_gnt;
    logic [NumCtrl-1:0][MemAddrWidth-1:0] src, dst;
    logic [NumCtrl-1:0][31:0] num_bytes;
    logic [31:0] launch_reply;
    logic [NumStreams-1:0] xfer_valid, xfer_ready, idle, complete;
    logic [MemAddrWidth-1:0] xfer_src, xfer_dst;
    logic [31:0] xfer_num_bytes;
    logic [NumStreams-1:0][dma_pkg::ID_W-1:0] next_ids, done_ids;

    for (genvar i = 0; i < NumCtrl; i++) begin : gen_reg_files
        dma_reg_file #(
            .NumStreams(NumStreams),
            .MemAddrWidth(MemAddrWidth),
            .PeriphIdWidth(PeriphIdWidth)
        ) i_reg_file (
            .clk_i(clk_i),
            .reset_i(reset_i),
            .ctrl_req_i(ctrl_req_i[i]),
            .ctrl_we_i(ctrl_we_i[i]),
            .ctrl_addr_i(ctrl_addr_i[i]),
            .ctrl_wdata_i(ctrl_wdata_i[i]),
            .ctrl_id_i(ctrl_id_i[i]),
            .ctrl_gnt_o(ctrl_gnt_o[i]),
            .ctrl_r_valid_o(ctrl_r_valid_o[i]),
            .ctrl_r_data_o(ctrl_r_data_o[i]),
            .ctrl_r_opc_o(ctrl_r_opc_o[i]),
            .ctrl_r_id_o(ctrl_r_id_o[i]),
            .launch_req_o(launch_req[i]),
            .src_o(src[i]),
            .dst_o(dst[i]),
            .num_bytes_o(num_bytes[i]),
            .launch_gnt_i(launch_gnt[i]),
            .launch_reply_i(launch_reply),
            .busy_i(busy_o),
            .done_ids_i(done_ids)
        );
    end

    dma_launch_ctrl #(
        .NumCtrl(NumCtrl),
        .NumStreams(NumStreams),
        .MemAddrWidth(MemAddrWidth)
    ) i_launch_ctrl (
        .clk_i(clk_i),
        .reset_i(reset_i),
        .launch_req_i(launch_req),
        .src_i(src),
        .dst_i(dst),
        .num_bytes_i(num_bytes),
        .launch_gnt_o(launch_gnt),
        .launch_reply_o(launch_reply),
        .xfer_valid_o(xfer_valid),
        .xfer_ready_i(xfer_ready),
        .xfer_src_o(xfer_src),
        .xfer_dst_o(xfer_dst),
        .xfer_num_bytes_o(xfer_num_bytes),
        .next_ids_i(next_ids),
        .idle_i(idle),
        .complete_i(complete),
        .busy_o(busy_o),
        .term_event_o(term_event_o),
        .term_irq_o(term_irq_o)
    );

    for (genvar s = 0; s < NumStreams; s++) begin : gen_backends
        dma_backend #(
            .MemAddrWidth(MemAddrWidth)
        ) i_backend (
            .clk_i(clk_i),
            .reset_i(reset_i),
            .xfer_valid_i(xfer_valid[s]),
            .xfer_ready_o(xfer_ready[s]),
            .src_i(xfer_src),
            .dst_i(xfer_dst),
            .num_bytes_i(xfer_num_bytes),
            .mem_req_o(mem_req_o[s]),
            .mem_we_o(mem_we_o[s]),
            .mem_addr_o(mem_addr_o[s]),
            .mem_wdata_o(mem_wdata_o[s]),
            .mem_gnt_i(mem_gnt_i[s]),
            .mem_rdata_i(mem_rdata_i[s]),
            .idle_o(idle[s]),
            .complete_o(complete[s]),
            .next_id_o(next_ids[s]),
            .done_id_o(done_ids[s])
        );
    end

endmodule

// File: hw/dma_backend.sv
/*
 * word copy engine on a req/gnt memory port,
 * with issued and retired transfer id counters
 */
`timescale 1ns/10ps
module dma_backend #(
    parameter int unsigned MemAddrWidth = 16
) (
    input  logic clk_i,
    input  logic reset_i,
    // transfer request
    input  logic xfer_valid_i,
    output logic xfer_ready_o,
    input  logic [MemAddrWidth-1:0] src_i,
    input  logic [MemAddrWidth-1:0] dst_i,
    input  logic [31:0] num_bytes_i,
    // memory port
    output logic mem_req_o,
    output logic mem_we_o,
    output logic [MemAddrWidth-1:0] mem_addr_o,
    output logic [31:0] mem_wdata_o,
    input  logic mem_gnt_i,
    input  logic [31:0] mem_rdata_i,
    // status
    output logic idle_o,
    output logic complete_o,
    output logic [dma_pkg::ID_W-1:0] next_id_o,
    output logic [dma_pkg::ID_W-1:0] done_id_o
);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_READ = 3'd1;
    localparam logic [2:0] ST_RDATA = 3'd2;
    localparam logic [2:0] ST_WRITE = 3'd3;
    localparam logic [2:0] ST_DONE = 3'd4;

    logic [2:0] state_q;
    logic [MemAddrWidth-1:0] src_q, dst_q;
    logic [29:0] words_q;
    logic [31:0] data_q;
    logic issue;

    assign xfer_ready_o = (state_q == ST_IDLE);
    assign issue = xfer_valid_i && xfer_ready_o;

    assign idle_o = (state_q == ST_IDLE);
    assign complete_o = (state_q == ST_DONE);

    assign mem_req_o = (state_q == ST_READ) || (state_q == ST_WRITE);
    assign mem_we_o = (state_q == ST_WRITE);
    assign mem_addr_o = (state_q == ST_WRITE) ? dst_q : src_q;
    assign mem_wdata_o = data_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (issue) begin
                        // less than a word left nothing to copy
                        state_q <= (num_bytes_i[31:2] == '0) ? ST_DONE : ST_READ;
                    end
                end
                ST_READ: begin
                    if (mem_gnt_i) begin
                        state_q <= ST_RDATA;
                    end
                end
                ST_RDATA: state_q <= ST_WRITE;
                ST_WRITE: begin
                    if (mem_gnt_i) begin
                        state_q <= (words_q == 30'd1) ? ST_DONE : ST_READ;
                    end
                end
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // descriptor and data path
    always_ff @(posedge clk_i) begin
        if (issue) begin
            src_q <= src_i;
            dst_q <= dst_i;
            words_q <= num_bytes_i[31:2];
        end
        // read data shows up one cycle after the read grant
        if (state_q == ST_RDATA) begin
            data_q <= mem_rdata_i;
        end
        if (state_q == ST_WRITE && mem_gnt_i) begin
            src_q <= src_q + MemAddrWidth'(4);
            dst_q <= dst_q + MemAddrWidth'(4);
            words_q <= words_q - 30'd1;
        end
    end

    // id counters, first issued id is 1
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            next_id_o <= dma_pkg::ID_W'(1);
            done_id_o <= '0;
        end else begin
            if (issue) begin
                next_id_o <= next_id_o + 1'b1;
            end
            if (complete_o) begin
                done_id_o <= done_id_o + 1'b1;
            end
        end
    end

endmodule

// File: hw/dma_launch_ctrl.sv
/*
 * round-robin launch arbiter across cores, strict rotation onto streams,
 * id reply, busy flag and completion events
 */
`timescale 1ns/10ps
module dma_launch_ctrl #(
    parameter int unsigned NumCtrl = 2,
    parameter int unsigned NumStreams = 2,
    parameter int unsigned MemAddrWidth = 16
) (
    input  logic clk_i,
    input  logic reset_i,
    // from the register files
    input  logic [NumCtrl-1:0] launch_req_i,
    input  logic [NumCtrl-1:0][MemAddrWidth-1:0] src_i,
    input  logic [NumCtrl-1:0][MemAddrWidth-1:0] dst_i,
    input  logic [NumCtrl-1:0][31:0] num_bytes_i,
    output logic [NumCtrl-1:0] launch_gnt_o,
    output logic [31:0] launch_reply_o,
    // to the backends
    output logic [NumStreams-1:0] xfer_valid_o,
    input  logic [NumStreams-1:0] xfer_ready_i,
    output logic [MemAddrWidth-1:0] xfer_src_o,
    output logic [MemAddrWidth-1:0] xfer_dst_o,
    output logic [31:0] xfer_num_bytes_o,
    input  logic [NumStreams-1:0][dma_pkg::ID_W-1:0] next_ids_i,
    input  logic [NumStreams-1:0] idle_i,
    input  logic [NumStreams-1:0] complete_i,
    // status and events
    output logic busy_o,
    output logic [NumCtrl-1:0] term_event_o,
    output logic [NumCtrl-1:0] term_irq_o
);

    localparam int unsigned CtrlIdxW = (NumCtrl > 1) ? $clog2(NumCtrl) : 1;
    localparam int unsigned StreamIdxW = (NumStreams > 1) ? $clog2(NumStreams) : 1;

    logic [CtrlIdxW-1:0] rr_ptr_q, winner;
    logic [StreamIdxW-1:0] str_ptr_q;
    logic found, accept;
    logic [dma_pkg::STREAM_IDX_W-1:0] reply_idx;
    logic event_q;

    // first requesting core at or after the priority pointer
    always_comb begin : proc_arbitrate
        int unsigned cand;
        found = 1'b0;
        winner = '0;
        for (int unsigned off = 0; off < NumCtrl; off++) begin
            cand = rr_ptr_q + off;
            if (cand >= NumCtrl) begin
                cand = cand - NumCtrl;
            end
            if (!found && launch_req_i[cand]) begin
                found = 1'b1;
                winner = CtrlIdxW'(cand);
            end
        end
    end

    // only the stream in turn may take it, even if others idle
    assign accept = found && xfer_ready_i[str_ptr_q];

    always_comb begin : proc_handshake
        for (int unsigned c = 0; c < NumCtrl; c++) begin
            launch_gnt_o[c] = accept && (winner == c);
        end
        for (int unsigned s = 0; s < NumStreams; s++) begin
            xfer_valid_o[s] = found && (str_ptr_q == s);
        end
    end

    assign xfer_src_o = src_i[winner];
    assign xfer_dst_o = dst_i[winner];
    assign xfer_num_bytes_o = num_bytes_i[winner];

    // reply is stream index on top, the id it is about to issue below
    always_comb begin : proc_reply
        reply_idx = '0;
        reply_idx[StreamIdxW-1:0] = str_ptr_q;
    end
    assign launch_reply_o = {reply_idx, next_ids_i[str_ptr_q]};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr_q <= '0;
            str_ptr_q <= '0;
            event_q <= 1'b0;
        end else begin
            event_q <= |complete_i;
            if (accept) begin
                rr_ptr_q <= (winner == CtrlIdxW'(NumCtrl - 1)) ? '0 : winner + 1'b1;
                str_ptr_q <= (str_ptr_q == StreamIdxW'(NumStreams - 1)) ? '0 : str_ptr_q + 1'b1;
            end
        end
    end

    assign busy_o = |(~idle_i);

    // every core sees every completion
    assign term_event_o = {NumCtrl{event_q}};
    assign term_irq_o = {NumCtrl{event_q}};

endmodule

// File: hw/dma_reg_file.sv
/*
 * per-core register set behind a 32-bit peripheral target port,
 * holds the descriptor and turns a next-id read into a launch request
 */
`timescale 1ns/10ps
module dma_reg_file #(
    parameter int unsigned NumStreams = 2,
    parameter int unsigned MemAddrWidth = 16,
    parameter int unsigned PeriphIdWidth = 4
) (
    input  logic clk_i,
    input  logic reset_i,
    // peripheral target port
    input  logic ctrl_req_i,
    input  logic ctrl_we_i,
    input  logic [dma_pkg::REG_ADDR_W-1:0] ctrl_addr_i,
    input  logic [31:0] ctrl_wdata_i,
    input  logic [PeriphIdWidth-1:0] ctrl_id_i,
    output logic ctrl_gnt_o,
    output logic ctrl_r_valid_o,
    output logic [31:0] ctrl_r_data_o,
    output logic ctrl_r_opc_o,
    output logic [PeriphIdWidth-1:0] ctrl_r_id_o,
    // towards the launch control
    output logic launch_req_o,
    output logic [MemAddrWidth-1:0] src_o,
    output logic [MemAddrWidth-1:0] dst_o,
    output logic [31:0] num_bytes_o,
    input  logic launch_gnt_i,
    input  logic [31:0] launch_reply_i,
    input  logic busy_i,
    input  logic [NumStreams-1:0][dma_pkg::ID_W-1:0] done_ids_i
);

    logic [MemAddrWidth-1:0] src_q, dst_q;
    logic [31:0] num_bytes_q;
    logic pending_q;
    logic launch_access;
    logic [dma_pkg::REG_ADDR_W-1:0] done_word;
    logic [dma_pkg::ID_W-1:0] done_sel;
    logic [31:0] rdata;
    logic unmapped;

    // a next-id read only launches with a nonzero byte count
    assign launch_access = ctrl_req_i && !ctrl_we_i
                           && (ctrl_addr_i == dma_pkg::NEXT_ID_OFFSET)
                           && (num_bytes_q != '0);

    // launches wait for the control module, everything else goes at once
    assign ctrl_gnt_o = launch_access ? launch_gnt_i : ctrl_req_i;
    assign launch_req_o = pending_q;

    assign src_o = src_q;
    assign dst_o = dst_q;
    assign num_bytes_o = num_bytes_q;

    // word index into the done-id window
    assign done_word = (ctrl_addr_i - dma_pkg::DONE_OFFSET) >> 2;

    always_comb begin : proc_done_sel
        done_sel = '0;
        for (int unsigned k = 0; k < NumStreams; k++) begin
            if (done_word == k) begin
                done_sel = done_ids_i[k];
            end
        end
    end

    always_comb begin : proc_read_mux
        rdata = '0;
        unmapped = 1'b0;
        case (ctrl_addr_i)
            dma_pkg::SRC_OFFSET: rdata = 32'(src_q);
            dma_pkg::DST_OFFSET: rdata = 32'(dst_q);
            dma_pkg::NUM_BYTES_OFFSET: rdata = num_bytes_q;
            dma_pkg::NEXT_ID_OFFSET: rdata = launch_access ? launch_reply_i : '0;
            dma_pkg::STATUS_OFFSET: rdata = {31'b0, busy_i};
            default: begin
                if (ctrl_addr_i >= dma_pkg::DONE_OFFSET && ctrl_addr_i[1:0] == 2'b00) begin
                    if (done_word < NumStreams) begin
                        rdata = {{(32 - dma_pkg::ID_W){1'b0}}, done_sel};
                    end else begin
                        rdata = dma_pkg::BAD_ACCESS;
                    end
                end else begin
                    unmapped = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            src_q <= '0;
            dst_q <= '0;
            num_bytes_q <= '0;
            pending_q <= 1'b0;
            ctrl_r_valid_o <= 1'b0;
        end else begin
            ctrl_r_valid_o <= ctrl_gnt_o;
            // request held for the control module until it is taken
            if (launch_gnt_i) begin
                pending_q <= 1'b0;
            end else if (launch_access) begin
                pending_q <= 1'b1;
            end
            if (ctrl_req_i && ctrl_we_i) begin
                case (ctrl_addr_i)
                    dma_pkg::SRC_OFFSET: src_q <= ctrl_wdata_i[MemAddrWidth-1:0];
                    dma_pkg::DST_OFFSET: dst_q <= ctrl_wdata_i[MemAddrWidth-1:0];
                    dma_pkg::NUM_BYTES_OFFSET: num_bytes_q <= ctrl_wdata_i;
                    default: ;
                endcase
            end
        end
    end

    // response fields, captured on the granting edge
    always_ff @(posedge clk_i) begin
        if (ctrl_gnt_o) begin
            ctrl_r_data_o <= ctrl_we_i ? 32'b0 : rdata;
            ctrl_r_opc_o <= unmapped;
            ctrl_r_id_o <= ctrl_id_i;
        end
    end

endmodule

// File: hw/dma_pkg.sv
/*
 * register map offsets, field widths and the invalid access pattern
 * shared by the DMA frontend modules
 */
package dma_pkg;

    // peripheral byte address width seen by each core
    localparam int unsigned REG_ADDR_W = 10;

    // register map, byte offsets
    localparam logic [REG_ADDR_W-1:0] SRC_OFFSET = 10'h000;
    localparam logic [REG_ADDR_W-1:0] DST_OFFSET = 10'h004;
    localparam logic [REG_ADDR_W-1:0] NUM_BYTES_OFFSET = 10'h008;
    localparam logic [REG_ADDR_W-1:0] NEXT_ID_OFFSET = 10'h00C;
    localparam logic [REG_ADDR_W-1:0] STATUS_OFFSET = 10'h010;

    // done-id register of stream k lives at DONE_OFFSET + 4*k
    localparam logic [REG_ADDR_W-1:0] DONE_OFFSET = 10'h014;

    // transfer id counters
    localparam int unsigned ID_W = 28;

    // stream index field on top of the id in a launch reply
    localparam int unsigned STREAM_IDX_W = 4;

    // returned for a done-id read past the last stream
    localparam logic [31:0] BAD_ACCESS = 32'hBADACCE5;

endpackage
